/* sd_cmd_phy.f */
design/sd_cmd_pkg.sv
design/sd_cmd_sync.sv
design/sd_cmd_rx.sv
design/sd_resp_tx.sv
design/sd_cmd_phy.sv
test/tb_sd_cmd_phy.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the SD CMD PHY testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f sd_cmd_phy.f \
   --top-module tb_sd_cmd_phy -o tb_sim &&
./obj_dir/tb_sim | tee sim.log &&
grep -qx "TEST RESULT: PASS" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* test/tb_sd_cmd_phy.sv */
/*
   Directed testbench for the SD CMD line PHY. Plays the host on CMD and
   the link side on the response request, then checks both directions.
*/

`timescale 1ns/1ps

module tb_sd_cmd_phy;

   logic                                  sd_clk;
   logic                                  reset_n;
   logic                                  sd_cmd_i;
   logic                                  sd_cmd_o;
   logic                                  sd_cmd_oe_o;
   logic [sd_cmd_pkg::CMD_BITS-1:0]       cmd_o;
   logic                                  cmd_crc_good_o;
   logic                                  cmd_valid_o;
   logic [sd_cmd_pkg::RESP_LONG_BITS-1:0] resp_i;
   sd_cmd_pkg::resp_type_t                resp_type_i;
   logic                                  resp_act_i;
   logic                                  crc_disable_i;
   logic                                  resp_done_o;

   int          mismatches;
   int          timeouts;

   sd_cmd_phy i_sd_cmd_phy (
      .sd_clk         (sd_clk),
      .reset_n        (reset_n),
      .sd_cmd_i       (sd_cmd_i),
      .sd_cmd_o       (sd_cmd_o),
      .sd_cmd_oe_o    (sd_cmd_oe_o),
      .cmd_o          (cmd_o),
      .cmd_crc_good_o (cmd_crc_good_o),
      .cmd_valid_o    (cmd_valid_o),
      .resp_i         (resp_i),
      .resp_type_i    (resp_type_i),
      .resp_act_i     (resp_act_i),
      .crc_disable_i  (crc_disable_i),
      .resp_done_o    (resp_done_o)
   );

   initial begin
      sd_clk = 1'b0;
      forever #5 sd_clk = ~sd_clk;
   end

   // generator x^7 + x^3 + 1 over data[nbits-1:0] MSB first
   function automatic logic [6:0] crc7_model(input logic [135:0] data, input int nbits);
      logic [6:0] c;
      logic       fb;
      c = 7'd0;
      for (int i = nbits - 1; i >= 0; i--) begin
         fb = data[i] ^ c[6];
         c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
      end
      return c;
   endfunction

   // start bit, transmission bit, index, argument, CRC7, end bit
   function automatic logic [47:0] build_cmd(input logic tx_bit, input logic [5:0] index,
                                             input logic [31:0] arg);
      logic [39:0] head;
      head = {1'b0, tx_bit, index, arg};
      return {head, crc7_model(136'(head), 40), 1'b1};
   endfunction

   function automatic logic [135:0] rand_resp();
      logic [31:0] r;
      r = $urandom;
      return {$urandom, $urandom, $urandom, $urandom, r[7:0]};
   endfunction

   task automatic report_mismatch(input string test, input logic [135:0] expected,
                                  input logic [135:0] actual);
      mismatches++;
      $display("FAILED %s expected %0h actual %0h", test, expected, actual);
   endtask

   // one bit per rising edge and returns once the end bit has been taken
   task automatic send_cmd(input logic [47:0] cmd);
      for (int i = 47; i >= 0; i--) begin
         @(posedge sd_clk);
         sd_cmd_i <= cmd[i];
      end
      @(posedge sd_clk);
      @(negedge sd_clk);
   endtask

   // bits change on the falling edge so the rising edge sees them settled
   task automatic capture_resp(input int nbits, output logic [135:0] bits);
      int n;
      bits = '0;
      n    = 0;
      while (!sd_cmd_oe_o && n < 50) begin
         @(posedge sd_clk);
         n++;
      end
      if (!sd_cmd_oe_o) begin
         timeouts++;
         $display("the DUT never started driving CMD");
         return;
      end
      // the new request has to clear the previous done flag
      if (resp_done_o !== 1'b0)
         report_mismatch("resp_done_clear", 136'(1'b0), 136'(resp_done_o));
      n = 0;
      while (sd_cmd_oe_o && n < 200) begin
         bits = {bits[134:0], sd_cmd_o};
         n++;
         @(posedge sd_clk);
      end
      if (sd_cmd_oe_o) begin
         timeouts++;
         $display("the DUT kept driving CMD past any response length");
      end else if (n != nbits) begin
         report_mismatch("resp_length", 136'(nbits), 136'(n));
      end
   endtask

   task automatic run_response(input sd_cmd_pkg::resp_type_t kind, input logic [135:0] data,
                               input int nbits, output logic [135:0] bits);
      int n;
      @(posedge sd_clk);
      resp_i      <= data;
      resp_type_i <= kind;
      resp_act_i  <= 1'b1;
      capture_resp(nbits, bits);
      n = 0;
      while (!resp_done_o && n < 20) begin
         @(posedge sd_clk);
         n++;
      end
      if (!resp_done_o) begin
         timeouts++;
         $display("resp_done_o did not rise after the response");
      end
      @(posedge sd_clk);
      resp_act_i <= 1'b0;
      // low level has to clear the synchronizer before the next request
      repeat (6) @(posedge sd_clk);
   endtask

   task automatic test_init_ignore();
      @(posedge sd_clk);
      sd_cmd_i <= 1'b1;
      repeat (5) @(posedge sd_clk);
      send_cmd(build_cmd(1'b1, 6'd0, 32'h0));
      if (cmd_valid_o !== 1'b0)
         report_mismatch("init_ignore", 136'(1'b0), 136'(cmd_valid_o));
      repeat (70) @(posedge sd_clk);
   endtask

   task automatic test_cmd_good(input int count);
      logic [31:0] r;
      logic [47:0] cmd;
      for (int n = 0; n < count; n++) begin
         r   = $urandom;
         cmd = build_cmd(r[0], r[6:1], $urandom);
         send_cmd(cmd);
         if (cmd_o !== cmd)
            report_mismatch("cmd_good", 136'(cmd), 136'(cmd_o));
         if (cmd_crc_good_o !== 1'b1)
            report_mismatch("cmd_good", 136'(1'b1), 136'(cmd_crc_good_o));
         if (cmd_valid_o !== cmd[46])
            report_mismatch("cmd_good", 136'(cmd[46]), 136'(cmd_valid_o));
      end
   endtask

   task automatic test_cmd_bad_crc();
      logic [47:0] bad;
      // flip the lowest CRC bit
      bad = build_cmd(1'b1, 6'd17, $urandom) ^ 48'h2;
      send_cmd(bad);
      if (cmd_o !== bad)
         report_mismatch("cmd_bad_crc", 136'(bad), 136'(cmd_o));
      if (cmd_crc_good_o !== 1'b0)
         report_mismatch("cmd_bad_crc", 136'(1'b0), 136'(cmd_crc_good_o));
      @(posedge sd_clk);
      crc_disable_i <= 1'b1;
      send_cmd(bad);
      if (cmd_crc_good_o !== 1'b1)
         report_mismatch("cmd_bad_crc_bypass", 136'(1'b1), 136'(cmd_crc_good_o));
      @(posedge sd_clk);
      crc_disable_i <= 1'b0;
   endtask

   task automatic test_resp_short(input sd_cmd_pkg::resp_type_t kind, input string name);
      logic [135:0] data;
      logic [135:0] cap;
      logic [6:0]   exp_crc;
      data = rand_resp();
      run_response(kind, data, 48, cap);
      // R3 carries no CRC so the field is all ones
      exp_crc = (kind == sd_cmd_pkg::RESP_R3) ? 7'h7f : crc7_model(136'(data[135:96]), 40);
      if (cap[47:8] !== data[135:96])
         report_mismatch(name, 136'(data[135:96]), 136'(cap[47:8]));
      if (cap[7:1] !== exp_crc)
         report_mismatch(name, 136'(exp_crc), 136'(cap[7:1]));
      if (cap[0] !== 1'b1)
         report_mismatch(name, 136'(1'b1), 136'(cap[0]));
   endtask

   task automatic test_resp_long();
      logic [135:0] data;
      logic [135:0] cap;
      logic [6:0]   exp_crc;
      data = rand_resp();
      run_response(sd_cmd_pkg::RESP_R2, data, 136, cap);
      exp_crc = crc7_model(136'(data[127:8]), 120);
      if (cap[135:8] !== data[135:8])
         report_mismatch("resp_long", 136'(data[135:8]), 136'(cap[135:8]));
      if (cap[7:1] !== exp_crc)
         report_mismatch("resp_long", 136'(exp_crc), 136'(cap[7:1]));
      if (cap[0] !== 1'b1)
         report_mismatch("resp_long", 136'(1'b1), 136'(cap[0]));
   endtask

   initial begin
      void'($urandom(32'hc3ce));
      mismatches    = 0;
      timeouts      = 0;
      reset_n       = 1'b0;
      sd_cmd_i      = 1'b0;
      resp_i        = '0;
      resp_type_i   = sd_cmd_pkg::RESP_R1;
      resp_act_i    = 1'b0;
      crc_disable_i = 1'b0;
      repeat (5) @(posedge sd_clk);
      reset_n <= 1'b1;
      test_init_ignore();
      test_cmd_good(8);
      test_cmd_bad_crc();
      test_resp_short(sd_cmd_pkg::RESP_R1, "resp_short_r1");
      test_resp_short(sd_cmd_pkg::RESP_R6, "resp_short_r6");
      test_resp_short(sd_cmd_pkg::RESP_R3, "resp_short_r3");
      test_resp_long();
      $display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* design/sd_cmd_phy.sv */
/*
   Top level of the card-side SD CMD line PHY. Wires the link-side
   synchronizer, the command receiver and the response transmitter.
*/

`timescale 1ns/1ps

module sd_cmd_phy (
   input  logic                                  sd_clk,
   input  logic                                  reset_n,

   // CMD line
   input  logic                                  sd_cmd_i,
   output logic                                  sd_cmd_o,
   output logic                                  sd_cmd_oe_o,

   // received command
   output logic [sd_cmd_pkg::CMD_BITS-1:0]       cmd_o,
   output logic                                  cmd_crc_good_o,
   output logic                                  cmd_valid_o,

   // response request from the link side
   input  logic [sd_cmd_pkg::RESP_LONG_BITS-1:0] resp_i,
   input  sd_cmd_pkg::resp_type_t                resp_type_i,
   input  logic                                  resp_act_i,
   input  logic                                  crc_disable_i,
   output logic                                  resp_done_o
);

   logic                   crc_disable_s;
   logic                   resp_start;
   sd_cmd_pkg::resp_type_t resp_type_s;
   logic                   sd_cmd_oe;

   assign sd_cmd_oe_o = sd_cmd_oe;

   sd_cmd_sync i_sd_cmd_sync (
      .sd_clk_i      (sd_clk),
      .reset_n_i     (reset_n),
      .resp_act_i    (resp_act_i),
      .resp_type_i   (resp_type_i),
      .crc_disable_i (crc_disable_i),
      .resp_start_o  (resp_start),
      .resp_type_o   (resp_type_s),
      .crc_disable_o (crc_disable_s)
   );

   sd_cmd_rx i_sd_cmd_rx (
      .sd_clk_i       (sd_clk),
      .reset_n_i      (reset_n),
      .sd_cmd_i       (sd_cmd_i),
      .sd_cmd_oe_i    (sd_cmd_oe),
      .crc_disable_i  (crc_disable_s),
      .cmd_o          (cmd_o),
      .cmd_crc_good_o (cmd_crc_good_o),
      .cmd_valid_o    (cmd_valid_o)
   );

   sd_resp_tx i_sd_resp_tx (
      .sd_clk_i     (sd_clk),
      .reset_n_i    (reset_n),
      .resp_start_i (resp_start),
      .resp_type_i  (resp_type_s),
      .resp_i       (resp_i),
      .sd_cmd_o     (sd_cmd_o),
      .sd_cmd_oe_o  (sd_cmd_oe),
      .resp_done_o  (resp_done_o)
   );

endmodule

/* design/sd_resp_tx.sv */
/*
   Card-side response transmitter. Drives R1, R1b, R3, R6, R7 and R2 onto
   CMD on the falling edge of sd_clk with CRC7 and end bit appended.
*/

`timescale 1ns/1ps

module sd_resp_tx (
   input  logic                                  sd_clk_i,
   input  logic                                  reset_n_i,
   input  logic                                  resp_start_i,
   input  sd_cmd_pkg::resp_type_t                resp_type_i,
   input  logic [sd_cmd_pkg::RESP_LONG_BITS-1:0] resp_i,
   output logic                                  sd_cmd_o,
   output logic                                  sd_cmd_oe_o,
   output logic                                  resp_done_o
);

   sd_cmd_pkg::tx_state_t  state;
   sd_cmd_pkg::resp_type_t type_q;

   logic [7:0]                              cnt;
   logic [sd_cmd_pkg::RESP_LONG_BITS-1:0]   resp_latch;
   logic [6:0]                              crc;
   logic                                    is_long;
   logic [7:0]                              end_cnt;
   logic [7:0]                              crc_first;

   // R2 is the only 136-bit response
   assign is_long   = (type_q == sd_cmd_pkg::RESP_R2);
   assign end_cnt   = is_long ? 8'(sd_cmd_pkg::RESP_LONG_BITS - 1)
                              : 8'(sd_cmd_pkg::RESP_SHORT_BITS - 1);
   assign crc_first = end_cnt - 8'(sd_cmd_pkg::CRC7_BITS);

   always_ff @(negedge sd_clk_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         state       <= sd_cmd_pkg::TX_RESET;
         cnt         <= '0;
         sd_cmd_oe_o <= 1'b0;
         resp_done_o <= 1'b0;
      end else begin
         case (state)
            sd_cmd_pkg::TX_RESET: begin
               sd_cmd_oe_o <= 1'b0;
               resp_done_o <= 1'b0;
               state       <= sd_cmd_pkg::TX_IDLE;
            end
            sd_cmd_pkg::TX_IDLE: begin
               if (resp_start_i) begin
                  resp_done_o <= 1'b0;
                  state       <= sd_cmd_pkg::TX_PREAMBLE;
               end
            end
            sd_cmd_pkg::TX_PREAMBLE: begin
               cnt   <= '0;
               state <= sd_cmd_pkg::TX_WRITE;
            end
            sd_cmd_pkg::TX_WRITE: begin
               sd_cmd_oe_o <= 1'b1;
               cnt         <= cnt + 8'd1;
               if (cnt == end_cnt) begin
                  state <= sd_cmd_pkg::TX_WRITE_END;
               end
            end
            sd_cmd_pkg::TX_WRITE_END: begin
               sd_cmd_oe_o <= 1'b0;
               resp_done_o <= 1'b1;
               state       <= sd_cmd_pkg::TX_IDLE;
            end
            default: begin
               state <= sd_cmd_pkg::TX_RESET;
            end
         endcase
      end
   end

   always_ff @(negedge sd_clk_i) begin
      case (state)
         sd_cmd_pkg::TX_IDLE: begin
            if (resp_start_i) begin
               resp_latch <= resp_i;
               type_q     <= resp_type_i;
               crc        <= '0;
            end
         end
         sd_cmd_pkg::TX_WRITE: begin
            // ones fill in behind the shifted bits
            resp_latch <= {resp_latch[sd_cmd_pkg::RESP_LONG_BITS-2:0], 1'b1};
            if (cnt >= crc_first) begin
               // CRC field, the ones shifted in last form the end bit
               sd_cmd_o <= crc[6];
               crc      <= {crc[5:0], 1'b1};
            end else begin
               sd_cmd_o <= resp_latch[sd_cmd_pkg::RESP_LONG_BITS-1];
               if (type_q == sd_cmd_pkg::RESP_R3) begin
                  crc <= '1;
               end else if (is_long && cnt < 8'(sd_cmd_pkg::R2_CRC_SKIP)) begin
                  // R2 header byte stays out of the CRC
                  crc <= '0;
               end else begin
                  crc <= sd_cmd_pkg::crc7_next(crc, resp_latch[sd_cmd_pkg::RESP_LONG_BITS-1]);
               end
            end
         end
         default: begin
            crc <= crc;
         end
      endcase
   end

   // line is released whenever the FSM is idle
   a_idle_released : assert property (
      @(negedge sd_clk_i) disable iff (!reset_n_i)
      (state == sd_cmd_pkg::TX_IDLE) |-> !sd_cmd_oe_o
   );

endmodule

/* design/sd_cmd_rx.sv */
/*
   Card-side command receiver. Waits out host power-up clocking, then
   samples 48-bit commands on the rising edge of sd_clk and checks CRC7.
*/

`timescale 1ns/1ps

module sd_cmd_rx (
   input  logic                            sd_clk_i,
   input  logic                            reset_n_i,
   input  logic                            sd_cmd_i,
   input  logic                            sd_cmd_oe_i,
   input  logic                            crc_disable_i,
   output logic [sd_cmd_pkg::CMD_BITS-1:0] cmd_o,
   output logic                            cmd_crc_good_o,
   output logic                            cmd_valid_o
);

   sd_cmd_pkg::rx_state_t state;

   logic [5:0]                      cnt;
   logic                            cmd_last;
   logic [sd_cmd_pkg::CMD_BITS-2:0] cmd_latch;
   logic [6:0]                      crc;

   always_ff @(posedge sd_clk_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         state          <= sd_cmd_pkg::RX_RESET;
         cnt            <= '0;
         cmd_last       <= 1'b0;
         cmd_valid_o    <= 1'b0;
         cmd_crc_good_o <= 1'b0;
      end else begin
         cmd_last <= sd_cmd_i;
         case (state)
            sd_cmd_pkg::RX_RESET: begin
               cnt <= '0;
               // host has powered the line
               if (sd_cmd_i) begin
                  state <= sd_cmd_pkg::RX_RESET_WAIT;
               end
            end
            sd_cmd_pkg::RX_RESET_WAIT: begin
               cnt <= cnt + 6'd1;
               if (cnt == 6'(sd_cmd_pkg::INIT_CLOCKS - 1)) begin
                  state <= sd_cmd_pkg::RX_IDLE;
               end
            end
            sd_cmd_pkg::RX_IDLE: begin
               // start bit, unless our own response is on the line
               if (!sd_cmd_i && cmd_last && !sd_cmd_oe_i) begin
                  cnt         <= '0;
                  cmd_valid_o <= 1'b0;
                  state       <= sd_cmd_pkg::RX_READ;
               end
            end
            sd_cmd_pkg::RX_READ: begin
               cnt <= cnt + 6'd1;
               if (cnt == 6'(sd_cmd_pkg::CMD_BITS - 3)) begin
                  state <= sd_cmd_pkg::RX_CHECK;
               end
            end
            sd_cmd_pkg::RX_CHECK: begin
               // latch holds bits 47..1, so [6:0] is the CRC field
               cmd_crc_good_o <= crc_disable_i | (cmd_latch[6:0] == crc);
               cmd_valid_o    <= cmd_latch[sd_cmd_pkg::CMD_BITS-3];
               state          <= sd_cmd_pkg::RX_IDLE;
            end
            default: begin
               state <= sd_cmd_pkg::RX_RESET;
            end
         endcase
      end
   end

   always_ff @(posedge sd_clk_i) begin
      case (state)
         sd_cmd_pkg::RX_IDLE: begin
            // start bit is zero, so a cleared CRC already covers it
            cmd_latch <= '0;
            crc       <= '0;
         end
         sd_cmd_pkg::RX_READ: begin
            cmd_latch <= {cmd_latch[sd_cmd_pkg::CMD_BITS-3:0], sd_cmd_i};
            if (cnt < 6'(sd_cmd_pkg::CMD_BITS - sd_cmd_pkg::CRC7_BITS - 2)) begin
               crc <= sd_cmd_pkg::crc7_next(crc, sd_cmd_i);
            end
         end
         sd_cmd_pkg::RX_CHECK: begin
            // end bit is taken straight from the line
            cmd_o <= {cmd_latch, sd_cmd_i};
         end
         default: begin
            crc <= crc;
         end
      endcase
   end

   // READ always runs the full command length
   a_read_length : assert property (
      @(posedge sd_clk_i) disable iff (!reset_n_i)
      (state == sd_cmd_pkg::RX_READ && cnt != 6'(sd_cmd_pkg::CMD_BITS - 3))
         |=> (state == sd_cmd_pkg::RX_READ)
   );

endmodule

/* design/sd_cmd_sync.sv */
/*
   Brings the link-side control inputs into the sd_clk domain through three
   flip-flops and turns the response request into a one-cycle start pulse.
*/

`timescale 1ns/1ps

module sd_cmd_sync (
   input  logic                   sd_clk_i,
   input  logic                   reset_n_i,
   input  logic                   resp_act_i,
   input  sd_cmd_pkg::resp_type_t resp_type_i,
   input  logic                   crc_disable_i,
   output logic                   resp_start_o,
   output sd_cmd_pkg::resp_type_t resp_type_o,
   output logic                   crc_disable_o
);

   // per stage: [5] resp_act, [4] crc_disable, [3:0] resp_type
   logic [2:0][5:0] sync_q;
   logic            act_last;

   always_ff @(posedge sd_clk_i or negedge reset_n_i) begin
      if (!reset_n_i) begin
         sync_q       <= '0;
         act_last     <= 1'b0;
         resp_start_o <= 1'b0;
      end else begin
         sync_q       <= {sync_q[1:0], {resp_act_i, crc_disable_i, resp_type_i}};
         act_last     <= sync_q[2][5];
         // registered edge detect, so the pulse trails the level by a cycle
         resp_start_o <= sync_q[2][5] & ~act_last;
      end
   end

   assign crc_disable_o = sync_q[2][4];
   assign resp_type_o   = sd_cmd_pkg::resp_type_t'(sync_q[2][3:0]);

   // a held request must still give only one start
   a_start_single : assert property (
      @(posedge sd_clk_i) disable iff (!reset_n_i)
      resp_start_o |=> !resp_start_o
   );

endmodule

/* design/sd_cmd_pkg.sv */
/*
   Shared types, constants and the CRC7 step for the SD card CMD line PHY.
   Referenced by package-scoped name from the RTL and the testbench.
*/

package sd_cmd_pkg;

   // command receiver FSM
   typedef enum logic [2:0] {
      RX_RESET,
      RX_RESET_WAIT,
      RX_IDLE,
      RX_READ,
      RX_CHECK
   } rx_state_t;

   // response transmitter FSM
   typedef enum logic [2:0] {
      TX_RESET,
      TX_IDLE,
      TX_PREAMBLE,
      TX_WRITE,
      TX_WRITE_END
   } tx_state_t;

   // SD mode response kinds
   typedef enum logic [3:0] {
      RESP_R1  = 4'd1,
      RESP_R1B = 4'd2,
      RESP_R2  = 4'd3,
      RESP_R3  = 4'd4,
      RESP_R6  = 4'd5,
      RESP_R7  = 4'd6
   } resp_type_t;

   localparam int CMD_BITS        = 48;
   localparam int RESP_SHORT_BITS = 48;
   localparam int RESP_LONG_BITS  = 136;
   localparam int CRC7_BITS       = 7;
   localparam int R2_CRC_SKIP     = 8;
   localparam int INIT_CLOCKS     = 60;

   // one bit of CRC7, polynomial x^7 + x^3 + 1
   function automatic logic [6:0] crc7_next(input logic [6:0] crc, input logic din);
      logic fb;
      fb = din ^ crc[6];
      return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
   endfunction

endpackage
